//--- common/simd_pkg.sv
// Shared types and constants of the SIMD integer execution unit
// Covers value widths, byte masks, opcodes, precision codes and fault codes

package simd_pkg;

	// ====================
	// Widths
	// ====================

	// One operand, result or exception vector of the 64-bit core
	localparam int VALUE_BITS = 64;

	// Number of bytes in one value, one copy-mask bit per byte
	localparam int BYTES = VALUE_BITS / 8;

	// Lane counts for each supported precision
	localparam int LANES16 = VALUE_BITS / 16;
	localparam int LANES32 = VALUE_BITS / 32;
	localparam int LANES64 = VALUE_BITS / 64;

	typedef logic [VALUE_BITS-1:0] value_t;

	// A set bit keeps the target byte instead of the result byte
	typedef logic [BYTES-1:0] byte_mask_t;

	// ====================
	// Operations
	// ====================

	typedef logic [2:0] alu_op_t;

	localparam alu_op_t OP_ADD = 3'd0;
	localparam alu_op_t OP_SUB = 3'd1;
	localparam alu_op_t OP_AND = 3'd2;
	localparam alu_op_t OP_OR  = 3'd3;
	localparam alu_op_t OP_XOR = 3'd4;
	localparam alu_op_t OP_SLL = 3'd5;
	localparam alu_op_t OP_SRL = 3'd6;
	// Iterative, finishes with mul_done
	localparam alu_op_t OP_MUL = 3'd7;

	// Lane width selection, code 3 is not a legal precision
	typedef enum logic [1:0] {
		PRC_WYDE  = 2'd0,
		PRC_TETRA = 2'd1,
		PRC_OCTA  = 2'd2
	} prec_t;

	// Exception code reported in every byte of a lane
	typedef logic [7:0] fault_t;

	localparam fault_t FLT_NONE  = 8'h00;
	// Signed overflow on add or subtract
	localparam fault_t FLT_OFLOW = 8'h21;

endpackage

//--- meta_alu/lane_mul.sv
// Iterative shift-and-add multiplier for one SIMD lane
// Takes one cycle per operand bit and returns the low half of the product

module lane_mul #(
	parameter int WIDTH = 16
) (
	input  logic             clk,
	input  logic             arst_n,
	input  logic             start,
	input  logic [WIDTH-1:0] a,
	input  logic [WIDTH-1:0] b,
	output logic [WIDTH-1:0] p,
	output logic             done
);

	typedef enum logic {
		IDLE,
		RUN
	} mul_state_t;

	mul_state_t               state;
	logic [$clog2(WIDTH)-1:0] cnt;
	// Running sum of the partial products
	logic [WIDTH-1:0]         acc;
	// Multiplicand moves left, multiplier moves right, one bit per cycle
	logic [WIDTH-1:0]         mcand;
	logic [WIDTH-1:0]         mplier;

	// Control state, cleared by reset
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= IDLE;
			cnt   <= '0;
			done  <= 1'b0;
		end else if (start) begin
			// A new start aborts any running product and drops done
			state <= RUN;
			cnt   <= '0;
			done  <= 1'b0;
		end else if (state == RUN) begin
			cnt <= cnt + 1'b1;
			// WIDTH is a power of two, so an all-ones count marks the last bit
			if (&cnt) begin
				state <= IDLE;
				done  <= 1'b1;
			end
		end
	end

	// Datapath, the last partial product lands on the edge where done rises
	always_ff @(posedge clk) begin
		if (start) begin
			acc    <= '0;
			mcand  <= a;
			mplier <= b;
		end else if (state == RUN) begin
			if (mplier[0])
				acc <= acc + mcand;
			mcand  <= mcand << 1;
			mplier <= mplier >> 1;
		end
	end

	assign p = acc;

	// A finished product never overlaps a running one
	a_done_not_busy: assert property (@(posedge clk) disable iff (!arst_n)
		!(done && state == RUN));

endmodule

//--- meta_alu/lane_alu.sv
// One lane of the SIMD execution unit
// Registers single-cycle results with their overflow fault and hosts the lane multiplier

module lane_alu
	import simd_pkg::*;
#(
	parameter int WIDTH = 16
) (
	input  logic             clk,
	input  logic             arst_n,
	input  logic             issue,
	input  alu_op_t          op,
	input  logic [WIDTH-1:0] a,
	input  logic [WIDTH-1:0] b,
	output logic [WIDTH-1:0] r,
	output fault_t           fault,
	output logic             mul_done
);

	logic [WIDTH-1:0]         sum;
	logic [WIDTH-1:0]         diff;
	logic [$clog2(WIDTH)-1:0] shamt;
	logic [WIDTH-1:0]         res_d;
	logic                     ovf_d;
	logic [WIDTH-1:0]         res_q;
	logic [WIDTH-1:0]         prod;
	logic                     mul_fin;
	alu_op_t                  op_q;

	// ====================
	// Single-cycle operations
	// ====================

	assign sum  = a + b;
	assign diff = a - b;

	// Shifts wrap the amount at the lane width
	assign shamt = b[$clog2(WIDTH)-1:0];

	always_comb begin
		res_d = '0;
		ovf_d = 1'b0;
		case (op)
			OP_ADD: begin
				res_d = sum;
				// Like signs in, different sign out
				ovf_d = (a[WIDTH-1] == b[WIDTH-1]) && (sum[WIDTH-1] != a[WIDTH-1]);
			end
			OP_SUB: begin
				res_d = diff;
				// Unlike signs in, result sign differs from a
				ovf_d = (a[WIDTH-1] != b[WIDTH-1]) && (diff[WIDTH-1] != a[WIDTH-1]);
			end
			OP_AND: res_d = a & b;
			OP_OR:  res_d = a | b;
			OP_XOR: res_d = a ^ b;
			OP_SLL: res_d = a << shamt;
			OP_SRL: res_d = a >> shamt;
			// The multiplier supplies the result later
			default: res_d = '0;
		endcase
	end

	// Result, fault and opcode are held until the next issue
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			op_q  <= OP_ADD;
			res_q <= '0;
			fault <= FLT_NONE;
		end else if (issue) begin
			op_q  <= op;
			res_q <= res_d;
			fault <= ovf_d ? FLT_OFLOW : FLT_NONE;
		end
	end

	// ====================
	// Multiplier
	// ====================

	lane_mul #(
		.WIDTH (WIDTH)
	) u_mul (
		.clk    (clk),
		.arst_n (arst_n),
		.start  (issue && (op == OP_MUL)),
		.a      (a),
		.b      (b),
		.p      (prod),
		.done   (mul_fin)
	);

	// The product shows while the last issued op is a multiply
	assign r = (op_q == OP_MUL) ? prod : res_q;

	// A finished product stays flagged only until the next issue of any op
	assign mul_done = mul_fin && (op_q == OP_MUL);

endmodule

//--- meta_alu/meta_alu.sv
// SIMD integer execution unit with selectable lane precision
// Builds lanes at 16, 32 and 64 bits, picks one precision and merges the
// result with a target value under a byte copy mask

module meta_alu
	import simd_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  logic       issue,
	input  alu_op_t    op,
	input  prec_t      prc,
	input  value_t     a,
	input  value_t     b,
	input  value_t     t,
	input  byte_mask_t cptgt,
	input  logic       z,
	output value_t     o,
	output value_t     exc,
	output logic       mul_done
);

	// Lane results and fault vectors at each precision
	value_t o16;
	value_t o32;
	value_t o64;
	value_t exc16;
	value_t exc32;
	value_t exc64;
	fault_t flt16 [LANES16];
	fault_t flt32 [LANES32];
	fault_t flt64 [LANES64];
	logic [LANES16-1:0] done16;
	logic [LANES32-1:0] done32;
	logic [LANES64-1:0] done64;

	// Issue-time copies of the precision and merge controls
	prec_t      prc_q;
	byte_mask_t cptgt_q;
	logic       z_q;
	value_t     t_q;

	// Outputs of the selected precision before the merge
	value_t sel_o;
	value_t sel_exc;

	// ====================
	// Lanes
	// ====================

	// Each lane repeats its fault code in every byte it spans
	for (genvar g = 0; g < LANES16; g++) begin : g_w16
		lane_alu #(
			.WIDTH (VALUE_BITS / LANES16)
		) u_lane (
			.clk      (clk),
			.arst_n   (arst_n),
			.issue    (issue),
			.op       (op),
			.a        (a[g*16 +: 16]),
			.b        (b[g*16 +: 16]),
			.r        (o16[g*16 +: 16]),
			.fault    (flt16[g]),
			.mul_done (done16[g])
		);
		assign exc16[g*16 +: 16] = {(BYTES / LANES16){flt16[g]}};
	end

	for (genvar g = 0; g < LANES32; g++) begin : g_w32
		lane_alu #(
			.WIDTH (VALUE_BITS / LANES32)
		) u_lane (
			.clk      (clk),
			.arst_n   (arst_n),
			.issue    (issue),
			.op       (op),
			.a        (a[g*32 +: 32]),
			.b        (b[g*32 +: 32]),
			.r        (o32[g*32 +: 32]),
			.fault    (flt32[g]),
			.mul_done (done32[g])
		);
		assign exc32[g*32 +: 32] = {(BYTES / LANES32){flt32[g]}};
	end

	for (genvar g = 0; g < LANES64; g++) begin : g_w64
		lane_alu #(
			.WIDTH (VALUE_BITS / LANES64)
		) u_lane (
			.clk      (clk),
			.arst_n   (arst_n),
			.issue    (issue),
			.op       (op),
			.a        (a[g*64 +: 64]),
			.b        (b[g*64 +: 64]),
			.r        (o64[g*64 +: 64]),
			.fault    (flt64[g]),
			.mul_done (done64[g])
		);
		assign exc64[g*64 +: 64] = {(BYTES / LANES64){flt64[g]}};
	end

	// ====================
	// Issue-time controls
	// ====================

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			prc_q   <= PRC_OCTA;
			cptgt_q <= '0;
			z_q     <= 1'b0;
			t_q     <= '0;
		end else if (issue) begin
			prc_q   <= prc;
			cptgt_q <= cptgt;
			z_q     <= z;
			t_q     <= t;
		end
	end

	// ====================
	// Precision select and merge
	// ====================

	// All lanes of the chosen width must be done for the unit to be done
	always_comb begin
		case (prc_q)
			PRC_WYDE: begin
				sel_o    = o16;
				sel_exc  = exc16;
				mul_done = &done16;
			end
			PRC_TETRA: begin
				sel_o    = o32;
				sel_exc  = exc32;
				mul_done = &done32;
			end
			default: begin
				sel_o    = o64;
				sel_exc  = exc64;
				mul_done = &done64;
			end
		endcase
	end

	// Masked bytes keep the target or go to zero, and report no fault
	for (genvar m = 0; m < BYTES; m++) begin : g_merge
		always_comb begin
			if (cptgt_q[m]) begin
				o[m*8 +: 8]   = z_q ? 8'h00 : t_q[m*8 +: 8];
				exc[m*8 +: 8] = FLT_NONE;
			end else begin
				o[m*8 +: 8]   = sel_o[m*8 +: 8];
				exc[m*8 +: 8] = sel_exc[m*8 +: 8];
			end
		end
	end

	// The issuing side never asks for the illegal precision code
	a_prc_legal: assert property (@(posedge clk) disable iff (!arst_n)
		issue |-> prc inside {PRC_WYDE, PRC_TETRA, PRC_OCTA});

	// Every issue drops the done level of the lanes in the next cycle
	a_issue_clears_done: assert property (@(posedge clk) disable iff (!arst_n)
		issue |=> !mul_done);

endmodule

//--- verification/alu_model.svh
// Reference model of the SIMD execution unit
// Lane operations, split by precision and byte merge with the target
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

function automatic int lane_bits(input prec_t p);
	return (p == PRC_WYDE) ? 16 : (p == PRC_TETRA) ? 32 : 64;
endfunction

// One lane with operands zero-extended; the result is cut back to w bits
function automatic value_t lane_result(input alu_op_t f, input value_t x, input value_t y,
		input int w);
	value_t r;
	case (f)
		OP_ADD:  r = x + y;
		OP_SUB:  r = x - y;
		OP_AND:  r = x & y;
		OP_OR:   r = x | y;
		OP_XOR:  r = x ^ y;
		OP_SLL:  r = x << (y % value_t'(w));
		OP_SRL:  r = x >> (y % value_t'(w));
		default: r = x * y;
	endcase
	return (w == 64) ? r : r & ((64'd1 << w) - 64'd1);
endfunction

// Overflow when the exact signed sum leaves the w-bit two's complement range
function automatic bit lane_oflow(input alu_op_t f, input value_t x, input value_t y,
		input int w);
	logic signed [65:0] sx;
	logic signed [65:0] sy;
	logic signed [65:0] s;
	logic signed [65:0] lim;
	lim = 66'sd1 <<< (w - 1);
	sx = $signed({2'b00, x});
	sy = $signed({2'b00, y});
	if (((x >> (w - 1)) & 64'd1) != 0)
		sx = sx - (lim <<< 1);
	if (((y >> (w - 1)) & 64'd1) != 0)
		sy = sy - (lim <<< 1);
	s = (f == OP_SUB) ? sx - sy : sx + sy;
	return (f == OP_ADD || f == OP_SUB) && (s >= lim || s < -lim);
endfunction

// Whole-value result, or with faults set the exception vector, one code per lane byte
function automatic value_t lane_split(input alu_op_t f, input prec_t p, input value_t x,
		input value_t y, input bit faults);
	int     w;
	value_t m;
	value_t r;
	w = lane_bits(p);
	m = (w == 64) ? '1 : (64'd1 << w) - 64'd1;
	r = '0;
	for (int i = 0; i < 64 / w; i++) begin
		if (!faults)
			r = r | (lane_result(f, (x >> (i * w)) & m, (y >> (i * w)) & m, w) << (i * w));
		else if (lane_oflow(f, (x >> (i * w)) & m, (y >> (i * w)) & m, w))
			r = r | (({8{FLT_OFLOW}} & m) << (i * w));
	end
	return r;
endfunction

// A set mask bit keeps the target byte, or zero when the zero flag is set
function automatic value_t merge_bytes(input value_t res, input value_t tgt,
		input byte_mask_t keep, input logic zero);
	value_t r;
	for (int k = 0; k < BYTES; k++)
		r[k*8 +: 8] = keep[k] ? (zero ? 8'h00 : tgt[k*8 +: 8]) : res[k*8 +: 8];
	return r;
endfunction

`endif

//--- verification/tb_meta_alu.sv
// Testbench for the SIMD execution unit
// Random operations from an xorshift generator, checked against the lane model

module tb_meta_alu
	import simd_pkg::*;
();

	// 230 operations at up to 70 cycles each, plus the reset time
	localparam int CYCLE_LIMIT = 230 * 70 + 16;

	logic       clk, arst_n, issue, z, mul_done;
	alu_op_t    op;
	prec_t      prc;
	value_t     a, b, t, o, exc;
	byte_mask_t cptgt;
	logic [31:0] rng, r;
	int cycles, checks, errors, test_checks, test_errors, oflows, waited;

	`include "alu_model.svh"

	meta_alu u_dut (.*);

	always #50 clk = ~clk;

	// ====================
	// Helpers
	// ====================

	// Xorshift32 step on the generator state
	function logic [31:0] next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	function prec_t draw_precision();
		logic [31:0] v;
		v = next_rand() % 32'd3;
		return prec_t'(v[1:0]);
	endfunction

	// Any opcode below OP_MUL finishes in one cycle
	function alu_op_t simple_op();
		logic [31:0] v;
		v = next_rand() % 32'd7;
		return v[2:0];
	endfunction

	task automatic check_value(input string name, input value_t got, input value_t want);
		test_checks++;
		if (got !== want) begin
			$display("ERR %s got %h expected %h", name, got, want);
			test_errors++;
		end
	endtask

	task automatic end_test(input string name);
		$display("test %s %0d checks, %0d errors", name, test_checks, test_errors);
		checks += test_checks;
		errors += test_errors;
		test_checks = 0;
		test_errors = 0;
	endtask

	// Inputs change on the falling edge, so the issue edge samples them cleanly
	task automatic issue_op(input alu_op_t f, input prec_t p, input value_t x, input value_t y,
			input value_t tv, input byte_mask_t keep, input logic zero);
		op = f;
		prc = p;
		a = x;
		b = y;
		t = tv;
		cptgt = keep;
		z = zero;
		issue = 1'b1;
		@(negedge clk);
		issue = 1'b0;
	endtask

	// One random operation, checked after its result is expected to be stable
	task automatic run_op(input alu_op_t f, input prec_t p, input byte_mask_t keep,
			input logic zero);
		value_t x, y, tv, want_o, want_exc;
		x = {next_rand(), next_rand()};
		y = {next_rand(), next_rand()};
		tv = {next_rand(), next_rand()};
		want_o = merge_bytes(lane_split(f, p, x, y, 1'b0), tv, keep, zero);
		want_exc = merge_bytes(lane_split(f, p, x, y, 1'b1), '0, keep, 1'b1);
		if (want_exc != '0)
			oflows++;
		issue_op(f, p, x, y, tv, keep, zero);
		// The issue edge drops the previous done level
		check_value("mul_done", {63'd0, mul_done}, 64'd0);
		if (f == OP_MUL) begin
			waited = 0;
			while (mul_done !== 1'b1) begin
				@(negedge clk);
				waited++;
			end
			if (waited < lane_bits(p)) begin
				$display("multiply of %0d-bit lanes finished after only %0d cycles",
					lane_bits(p), waited);
				test_errors++;
			end
		end
		check_value("o", o, want_o);
		check_value("exc", exc, want_exc);
	endtask

	// ====================
	// Tests
	// ====================

	initial begin
		clk = 1'b0;
		arst_n = 1'b0;
		issue = 1'b0;
		z = 1'b0;
		op = OP_ADD;
		prc = PRC_WYDE;
		a = '0;
		b = '0;
		t = '0;
		cptgt = '0;
		rng = 32'h971c;
		{checks, errors, test_checks, test_errors, oflows} = '0;
		repeat (16) @(negedge clk);
		arst_n = 1'b1;
		check_value("o", o, 64'd0);
		check_value("exc", exc, 64'd0);
		check_value("mul_done", {63'd0, mul_done}, 64'd0);
		end_test("reset");
		repeat (60) run_op(simple_op(), draw_precision(), '0, 1'b0);
		end_test("alu");
		oflows = 0;
		repeat (40) run_op((next_rand() & 1) ? OP_SUB : OP_ADD, draw_precision(), '0, 1'b0);
		if (oflows == 0) begin
			$display("no add or subtract in the overflow test overflowed any lane");
			test_errors++;
		end
		end_test("overflow");
		repeat (50) begin
			r = next_rand();
			run_op(simple_op(), draw_precision(), r[7:0], r[8]);
		end
		end_test("mask");
		for (int p = 0; p < 3; p++) begin
			repeat (10) begin
				r = next_rand();
				run_op(OP_MUL, prec_t'(p[1:0]), r[7:0], r[8]);
				// A one-cycle op right after the product must clear mul_done
				run_op(simple_op(), prec_t'(p[1:0]), '0, 1'b0);
			end
		end
		end_test("multiply");
		// A second multiply aborts the first and only its own done may rise
		repeat (10) begin
			r = next_rand();
			issue_op(OP_MUL, draw_precision(), {next_rand(), next_rand()},
				{next_rand(), next_rand()}, '0, '0, 1'b0);
			repeat (1 + r % 8) begin
				check_value("mul_done", {63'd0, mul_done}, 64'd0);
				@(negedge clk);
			end
			run_op(OP_MUL, draw_precision(), r[15:8], r[16]);
		end
		end_test("abort");
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles, the tests did not finish", cycles);
		$display("Something failed");
		$finish;
	end

endmodule

//--- tb.f
+incdir+verification
common/simd_pkg.sv
meta_alu/lane_mul.sv
meta_alu/lane_alu.sv
meta_alu/meta_alu.sv
verification/tb_meta_alu.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the meta_alu testbench with Verilator, then judge the log
set -o pipefail
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module tb_meta_alu -f tb.f -o tb_meta_alu \
	&& ./obj_dir/tb_meta_alu | tee sim.log \
	|| { echo "build or simulation error"; exit 1; }
grep -q "Something failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }
